// ==== bench/tb_u2_ctrl.sv ====
//////////////////////////////////////////////////
// Testbench for the control-plane subsystem with random
// bus traffic checked against a local model
//////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_u2_ctrl;
   import u2_ctrl_pkg::*;

   localparam int N_CFG      = 40;
   localparam int N_LED      = 30;
   localparam int N_PERIODS  = 3;
   localparam int MAX_PERIOD = 20;
   // Cycles per phase times a wide margin
   localparam int MAX_CYCLES = 12 * (N_CFG * 8 + N_LED * 16 + N_PERIODS * MAX_PERIOD * 4 + 500);

   logic          wb_clk = 1'b0;
   logic          wb_rst;
   logic [AW-1:0] wb_adr_i;
   logic [DW-1:0] wb_dat_i;
   logic          wb_we_i, wb_cyc_i, wb_stb_i;
   logic [DW-1:0] wb_dat_o;
   logic          wb_ack_o, wb_err_o, int_o;
   logic          clk_status_i, phy_int_n_i, sim_mode_i;
   logic [3:0]    clock_divider_i;
   logic [7:0]    leds_o;
   logic          clock_ready_o;
   logic [1:0]    clk_en_o, clk_sel_o;
   logic          ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o;
   logic          adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o;
   logic          phy_reset_n_o;

   int unsigned   cycles = 0;

   // Model of the setting registers and the mask
   logic [7:0]    m_clk, m_ser, m_adc, m_led_sw, m_led_src;
   logic          m_phy;
   logic [DW-1:0] m_mask;

   int            i, n, p;
   int unsigned   n1;
   set_addr_t     sa;
   logic [5:0]    win;
   logic [DW-1:0] rd, c1, c2, exp_irq, exp_word;
   logic          got_err;

   u2_ctrl_top u2_ctrl_top_i (.*);

   always #2 wb_clk = ~wb_clk;

   //////////////////////////////////////////////////
   // Cycle limit and assertion watch
   always @(negedge wb_clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: the run went past %0d cycles", MAX_CYCLES);
         $display("Some tests failed");
         $fatal(1, "Stopped by the cycle limit");
      end
      if (u2_ctrl_top_i.u_decode.u_bus_checks.fail_count != 0) begin
         $display("A bus protocol assertion failed at %0t ns", $time);
         $display("Some tests failed");
         $fatal(1, "Stopped on an assertion failure");
      end
   end

   task automatic stop_with_error(input string why);
      $display("Error at %0t ns: %s", $time, why);
      $display("Some tests failed");
      $fatal(1, "Run stopped");
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         $display("FAILED at %0t ns: %s expected %h actual %h", $time, name, expected, actual);
         $display("Some tests failed");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   function automatic logic [AW-1:0] set_adr(input set_addr_t a);
      return {SLV_SET_ADDR, a, 2'b00};
   endfunction

   function automatic logic [AW-1:0] pic_adr(input logic [2:0] word);
      return {SLV_PIC_ADDR, 5'b0, word, 2'b00};
   endfunction

   function automatic logic [AW-1:0] rdbk_adr(input logic [3:0] word);
      return {SLV_RDBK_ADDR, 4'b0, word, 2'b00};
   endfunction

   // One access that waits for ack or err
   task automatic bus_cycle(input logic [AW-1:0] adr, input logic we, input logic [DW-1:0] wdata,
                            output logic [DW-1:0] rdata, output logic err);
      int waited;
      waited = 0;
      @(posedge wb_clk);
      wb_adr_i <= adr;
      wb_dat_i <= wdata;
      wb_we_i  <= we;
      wb_cyc_i <= 1'b1;
      wb_stb_i <= 1'b1;
      @(negedge wb_clk);
      while (!wb_ack_o && !wb_err_o && waited < 8) begin
         @(negedge wb_clk);
         waited++;
      end
      if (!wb_ack_o && !wb_err_o)
         stop_with_error("no ack or err within 8 cycles of a bus request");
      check_value("response latency", 1, waited);
      rdata = wb_dat_o;
      err   = wb_err_o;
      @(posedge wb_clk);
      wb_stb_i <= 1'b0;
      wb_cyc_i <= 1'b0;
      wb_we_i  <= 1'b0;
   endtask

   task automatic write_word(input logic [AW-1:0] adr, input logic [DW-1:0] data);
      logic [DW-1:0] rd_dummy;
      logic          err;
      bus_cycle(adr, 1'b1, data, rd_dummy, err);
      check_value("wb_err_o", 0, err);
   endtask

   task automatic read_word(input logic [AW-1:0] adr, output logic [DW-1:0] data);
      logic err;
      bus_cycle(adr, 1'b0, '0, data, err);
      check_value("wb_err_o", 0, err);
   endtask

   task automatic write_setting(input set_addr_t a, input logic [DW-1:0] data);
      write_word(set_adr(a), data);
      case (a)
         SR_CLK:     m_clk     = data[7:0];
         SR_SER:     m_ser     = data[7:0];
         SR_ADC:     m_adc     = data[7:0];
         SR_LED:     m_led_sw  = data[7:0];
         SR_PHY:     m_phy     = data[0];
         SR_LED_SRC: m_led_src = data[7:0];
         default:    ;
      endcase
   endtask

   // Pin layout follows the byte views of each register
   task automatic check_pins();
      logic [7:0] hw, leds_exp;
      int         b;
      hw    = '0;
      hw[2] = clk_status_i;
      for (b = 0; b < 8; b++)
         leds_exp[b] = m_led_src[b] ? hw[b] : m_led_sw[b];
      check_value("clock_ready_o", m_clk[4], clock_ready_o);
      check_value("clk_en_o", m_clk[3:2], clk_en_o);
      check_value("clk_sel_o", m_clk[1:0], clk_sel_o);
      check_value("ser_enable_o", m_ser[3], ser_enable_o);
      check_value("ser_prbsen_o", m_ser[2], ser_prbsen_o);
      check_value("ser_loopen_o", m_ser[1], ser_loopen_o);
      check_value("ser_rx_en_o", m_ser[0], ser_rx_en_o);
      check_value("adc_oe_a_o", m_adc[3], adc_oe_a_o);
      check_value("adc_on_a_o", m_adc[2], adc_on_a_o);
      check_value("adc_oe_b_o", m_adc[1], adc_oe_b_o);
      check_value("adc_on_b_o", m_adc[0], adc_on_b_o);
      check_value("phy_reset_n_o", !m_phy, phy_reset_n_o);
      check_value("leds_o", leds_exp, leds_o);
   endtask

   // Polls the pending word until a bit is set
   task automatic wait_pending(input int bit_pos, input int unsigned limit, input string what);
      logic [DW-1:0] rd_p;
      int unsigned   start;
      start = cycles;
      rd_p  = '0;
      while (!rd_p[bit_pos]) begin
         if (cycles - start > limit)
            stop_with_error({what, " interrupt never became pending"});
         read_word(pic_adr(3'd1), rd_p);
      end
   endtask

   initial begin
      void'($urandom(32'h4c98_468f));
      wb_rst          = 1'b1;
      wb_adr_i        = '0;
      wb_dat_i        = '0;
      wb_we_i         = 1'b0;
      wb_cyc_i        = 1'b0;
      wb_stb_i        = 1'b0;
      clk_status_i    = 1'b1;
      phy_int_n_i     = 1'b1;
      sim_mode_i      = 1'b0;
      clock_divider_i = 4'd0;
      m_clk     = '0;
      m_ser     = '0;
      m_adc     = '0;
      m_led_sw  = '0;
      m_led_src = LED_SRC_RESET;
      m_phy     = 1'b0;
      m_mask    = '0;
      repeat (5) @(posedge wb_clk);
      wb_rst <= 1'b0;

      // Reset values
      @(negedge wb_clk);
      check_pins();
      check_value("wb_ack_o", 0, wb_ack_o);
      check_value("wb_err_o", 0, wb_err_o);
      check_value("int_o", 0, int_o);

      // Random setting writes including unused addresses
      for (i = 0; i < N_CFG; i++) begin
         case ($urandom_range(4, 0))
            0:       sa = SR_CLK;
            1:       sa = SR_SER;
            2:       sa = SR_ADC;
            3:       sa = SR_PHY;
            default: begin
               sa = set_addr_t'($urandom_range(255, 16));
               if (sa == SR_SIMTIMER || sa == SR_SIMTIMER + 8'd1)
                  sa = 8'd100;
            end
         endcase
         write_setting(sa, $urandom());
         @(negedge wb_clk);
         check_pins();
      end

      // LED source mux
      for (i = 0; i < N_LED; i++) begin
         write_setting(SR_LED, $urandom());
         write_setting(SR_LED_SRC, $urandom());
         @(posedge wb_clk);
         clk_status_i <= 1'($urandom_range(1, 0));
         @(negedge wb_clk);
         check_pins();
      end

      //////////////////////////////////////////////////
      // Readback window
      @(posedge wb_clk);
      sim_mode_i      <= 1'($urandom_range(1, 0));
      clock_divider_i <= 4'($urandom_range(15, 0));
      phy_int_n_i     <= 1'($urandom_range(1, 0));
      read_word(rdbk_adr(4'd9), rd);
      exp_word      = '0;
      exp_word[31]  = sim_mode_i;
      exp_word[3:0] = clock_divider_i;
      check_value("readback word 9", exp_word, rd);
      read_word(rdbk_adr(4'd12), rd);
      check_value("readback word 12", 32'd3, rd);
      exp_irq                 = '0;
      exp_irq[IRQ_PHY]        = phy_int_n_i;
      exp_irq[IRQ_CLK_STATUS] = clk_status_i;
      read_word(rdbk_adr(4'd13), rd);
      check_value("readback word 13", exp_irq, rd);
      read_word(rdbk_adr(4'd15), c1);
      n1 = cycles;
      repeat ($urandom_range(20, 1)) @(posedge wb_clk);
      read_word(rdbk_adr(4'd15), c2);
      check_value("cycle count grows with the ack gap", 1, (c2 - c1) >= (cycles - n1));

      // One-shot timer into the PIC
      m_mask = 32'd1 << IRQ_ONETIME;
      write_word(pic_adr(3'd0), m_mask);
      write_word(pic_adr(3'd1), 32'hFFFF_FFFF);
      read_word(pic_adr(3'd0), rd);
      check_value("pic mask", m_mask, rd);
      n = $urandom_range(40, 3);
      write_setting(SR_SIMTIMER, n);
      wait_pending(IRQ_ONETIME, n + 16, "one-shot");
      @(negedge wb_clk);
      check_value("int_o", 1, int_o);
      write_word(pic_adr(3'd1), m_mask);
      repeat (n + 8) @(posedge wb_clk);
      read_word(pic_adr(3'd1), rd);
      check_value("pending one-shot after clear", 0, rd[IRQ_ONETIME]);
      @(negedge wb_clk);
      check_value("int_o", 0, int_o);

      // Periodic timer until a zero period stops it
      p = $urandom_range(MAX_PERIOD, 4);
      write_setting(SR_SIMTIMER + 8'd1, p);
      for (i = 0; i < N_PERIODS; i++) begin
         wait_pending(IRQ_PERIODIC, p + 16, "periodic");
         write_word(pic_adr(3'd1), 32'd1 << IRQ_PERIODIC);
      end
      write_setting(SR_SIMTIMER + 8'd1, 0);
      write_word(pic_adr(3'd1), 32'd1 << IRQ_PERIODIC);
      repeat (2 * p + 4) @(posedge wb_clk);
      read_word(pic_adr(3'd1), rd);
      check_value("pending periodic after stop", 0, rd[IRQ_PERIODIC]);

      // Rising edge on clk_status_i
      @(posedge wb_clk);
      clk_status_i <= 1'b0;
      repeat (3) @(posedge wb_clk);
      write_word(pic_adr(3'd1), 32'd1 << IRQ_CLK_STATUS);
      read_word(pic_adr(3'd1), rd);
      check_value("pending clk_status before edge", 0, rd[IRQ_CLK_STATUS]);
      @(posedge wb_clk);
      clk_status_i <= 1'b1;
      repeat (3) @(posedge wb_clk);
      read_word(pic_adr(3'd1), rd);
      check_value("pending clk_status after edge", 1, rd[IRQ_CLK_STATUS]);

      // Unmapped windows answer with err
      for (i = 0; i < 8; i++) begin
         do
            win = 6'($urandom_range(63, 0));
         while (win == SLV_RDBK_ADDR || win == SLV_SET_ADDR || win == SLV_PIC_ADDR);
         bus_cycle({win, 10'($urandom())}, 1'($urandom_range(1, 0)), $urandom(), rd, got_err);
         check_value("wb_err_o on unmapped window", 1, got_err);
      end

      repeat (4) @(posedge wb_clk);
      if (u2_ctrl_top_i.u_decode.u_bus_checks.fail_count == 0) begin
         $display("All tests passed");
         $finish;
      end else begin
         $display("Some tests failed");
         $fatal(1, "Bus protocol assertions failed");
      end
   end

endmodule

// ==== bench/u2_ctrl_assertions.sv ====
//////////////////////////////////////////////////
// Wishbone response checks, bound to the decoder
//////////////////////////////////////////////////

`timescale 1ns/1ns

module u2_ctrl_assertions (
   input logic wb_clk,
   input logic wb_rst,
   input logic cyc_i,
   input logic stb_i,
   input logic ack_i,
   input logic err_i
);

   // Number of failed assertions so far
   int fail_count = 0;

   // Ack and err are exclusive
   a_ack_err_excl: assert property (@(posedge wb_clk) disable iff (wb_rst)
      !(ack_i && err_i))
      else begin
         $error("ack and err are high in the same cycle");
         fail_count++;
      end

   // A response follows a request in the cycle before
   a_resp_after_stb: assert property (@(posedge wb_clk) disable iff (wb_rst)
      (ack_i || err_i) |-> $past(cyc_i && stb_i))
      else begin
         $error("response without a request in the previous cycle");
         fail_count++;
      end

   // Responses last one cycle
   a_resp_one_cycle: assert property (@(posedge wb_clk) disable iff (wb_rst)
      (ack_i || err_i) |=> !(ack_i || err_i))
      else begin
         $error("response held longer than one cycle");
         fail_count++;
      end

endmodule

bind wb_slave_decode u2_ctrl_assertions u_bus_checks (
   .wb_clk(wb_clk),
   .wb_rst(wb_rst),
   .cyc_i(cyc_i),
   .stb_i(stb_i),
   .ack_i(ack_o),
   .err_i(err_o)
);

// ==== rtl/control_regs.sv ====
//////////////////////////////////////////////////
// Board control setting registers and the LED mux
//////////////////////////////////////////////////

`timescale 1ns/1ns

module control_regs (
   input  logic                       wb_clk,
   input  logic                       wb_rst,
   input  logic                       set_stb_i,
   input  u2_ctrl_pkg::set_addr_t     set_addr_i,
   input  logic [u2_ctrl_pkg::DW-1:0] set_data_i,
   input  logic                       clk_status_i,
   output logic [7:0]                 leds_o,
   output logic                       clock_ready_o,
   output logic [1:0]                 clk_en_o,
   output logic [1:0]                 clk_sel_o,
   output logic                       ser_enable_o,
   output logic                       ser_prbsen_o,
   output logic                       ser_loopen_o,
   output logic                       ser_rx_en_o,
   output logic                       adc_oe_a_o,
   output logic                       adc_on_a_o,
   output logic                       adc_oe_b_o,
   output logic                       adc_on_b_o,
   output logic                       phy_reset_n_o
);
   import u2_ctrl_pkg::*;

   ctrl_byte_u clk_byte, ser_byte, adc_byte;
   logic [7:0] led_sw, led_src, led_hw;
   logic       phy_rst;

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         clk_byte <= '0;
         ser_byte <= '0;
         adc_byte <= '0;
         led_sw   <= '0;
         led_src  <= LED_SRC_RESET;
         phy_rst  <= 1'b0;
      end else if (set_stb_i) begin
         case (set_addr_i)
            SR_CLK:     clk_byte <= set_data_i[7:0];
            SR_SER:     ser_byte <= set_data_i[7:0];
            SR_ADC:     adc_byte <= set_data_i[7:0];
            SR_LED:     led_sw   <= set_data_i[7:0];
            SR_PHY:     phy_rst  <= set_data_i[0];
            SR_LED_SRC: led_src  <= set_data_i[7:0];
            default:    ;
         endcase
      end
   end

   // Unpack each byte through its own view
   assign {clock_ready_o, clk_en_o, clk_sel_o} =
      {clk_byte.clk.clock_ready, clk_byte.clk.clk_en, clk_byte.clk.clk_sel};
   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} =
      {ser_byte.ser.enable, ser_byte.ser.prbsen, ser_byte.ser.loopen, ser_byte.ser.rx_en};
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} =
      {adc_byte.adc.oe_a, adc_byte.adc.on_a, adc_byte.adc.oe_b, adc_byte.adc.on_b};

   assign phy_reset_n_o = ~phy_rst;

   //////////////////////////////////////////////////
   // LEDs, source bit 1 selects hardware
   assign led_hw = {5'b0, clk_status_i, 2'b0};
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

// ==== rtl/pic.sv ====
//////////////////////////////////////////////////
// Edge-triggered interrupt controller, word 0 mask,
// word 1 pending with write-one-to-clear
//////////////////////////////////////////////////

`timescale 1ns/1ns

module pic (
   input  logic                       wb_clk,
   input  logic                       wb_rst,
   input  logic [2:0]                 adr_i,
   input  logic [u2_ctrl_pkg::DW-1:0] dat_i,
   input  logic                       we_i,
   input  logic                       stb_i,
   input  logic                       cyc_i,
   input  logic [u2_ctrl_pkg::DW-1:0] irq_i,
   output logic [u2_ctrl_pkg::DW-1:0] dat_o,
   output logic                       ack_o,
   output logic                       int_o
);
   import u2_ctrl_pkg::*;

   logic [DW-1:0] mask, pending, irq_d, rise, clr;
   logic          acc;

   assign acc  = stb_i & cyc_i & ~ack_o;
   assign rise = irq_i & ~irq_d;
   assign clr  = (acc && we_i && adr_i == 3'd1) ? dat_i : '0;

   // Previous IRQ levels for edge detect
   always_ff @(posedge wb_clk) begin
      irq_d <= irq_i;
   end

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         ack_o   <= 1'b0;
         mask    <= '0;
         pending <= '0;
         int_o   <= 1'b0;
      end else begin
         ack_o <= acc;
         if (acc && we_i && adr_i == 3'd0)
            mask <= dat_i;
         // A new edge wins over a clear in the same cycle
         pending <= (pending & ~clr) | rise;
         int_o   <= |(pending & mask);
      end
   end

   always_ff @(posedge wb_clk) begin
      if (acc) begin
         case (adr_i)
            3'd0:    dat_o <= mask;
            3'd1:    dat_o <= pending;
            default: dat_o <= '0;
         endcase
      end
   end

endmodule

// ==== rtl/readback_mux.sv ====
//////////////////////////////////////////////////
// Read-only status window with the cycle counter
//////////////////////////////////////////////////

`timescale 1ns/1ns

module readback_mux (
   input  logic                       wb_clk,
   input  logic                       wb_rst,
   input  logic [3:0]                 adr_i,
   input  logic                       stb_i,
   input  logic [u2_ctrl_pkg::DW-1:0] irq_i,
   input  logic                       sim_mode_i,
   input  logic [3:0]                 clock_divider_i,
   output logic [u2_ctrl_pkg::DW-1:0] dat_o,
   output logic                       ack_o
);
   import u2_ctrl_pkg::*;

   logic [DW-1:0] cycle_count;

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         cycle_count <= '0;
         ack_o       <= 1'b0;
      end else begin
         cycle_count <= cycle_count + 1'b1;
         ack_o       <= stb_i & ~ack_o;
      end
   end

   always_ff @(posedge wb_clk) begin
      case (adr_i)
         4'd9:    dat_o <= {sim_mode_i, 27'b0, clock_divider_i};
         4'd12:   dat_o <= COMPAT_NUM;
         4'd13:   dat_o <= irq_i;
         4'd15:   dat_o <= cycle_count;
         default: dat_o <= '0;
      endcase
   end

endmodule

// ==== rtl/settings_bus.sv ====
//////////////////////////////////////////////////
// Wishbone write to settings strobe, address and data
//////////////////////////////////////////////////

`timescale 1ns/1ns

module settings_bus (
   input  logic                       wb_clk,
   input  logic                       wb_rst,
   input  logic [u2_ctrl_pkg::AW-1:0] adr_i,
   input  logic [u2_ctrl_pkg::DW-1:0] dat_i,
   input  logic                       stb_i,
   input  logic                       we_i,
   output logic                       ack_o,
   output logic                       set_stb_o,
   output u2_ctrl_pkg::set_addr_t     set_addr_o,
   output logic [u2_ctrl_pkg::DW-1:0] set_data_o
);

   logic take;

   assign take = stb_i & ~ack_o;

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         ack_o     <= 1'b0;
         set_stb_o <= 1'b0;
      end else begin
         ack_o     <= take;
         // Reads ack but never strobe
         set_stb_o <= take & we_i;
      end
   end

   // Word address and data, held until the next access
   always_ff @(posedge wb_clk) begin
      if (take) begin
         set_addr_o <= adr_i[9:2];
         set_data_o <= dat_i;
      end
   end

endmodule

// ==== rtl/simple_timer.sv ====
//////////////////////////////////////////////////
// One-shot and periodic interrupt timer, set over
// the settings bus
//////////////////////////////////////////////////

`timescale 1ns/1ns

module simple_timer (
   input  logic                       wb_clk,
   input  logic                       wb_rst,
   input  logic                       set_stb_i,
   input  u2_ctrl_pkg::set_addr_t     set_addr_i,
   input  logic [u2_ctrl_pkg::DW-1:0] set_data_i,
   output logic                       onetime_int_o,
   output logic                       periodic_int_o
);
   import u2_ctrl_pkg::*;

   logic [DW-1:0] onetime_cnt;
   logic [DW-1:0] period, period_cnt;

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         onetime_cnt <= '0;
         period      <= '0;
         period_cnt  <= '0;
      end else begin
         // One-shot counts down to zero and stays there
         if (set_stb_i && set_addr_i == SR_SIMTIMER)
            onetime_cnt <= set_data_i;
         else if (onetime_cnt != '0)
            onetime_cnt <= onetime_cnt - 1'b1;

         // Periodic reloads from the period on each fire
         if (set_stb_i && set_addr_i == SR_SIMTIMER + 8'd1) begin
            period     <= set_data_i;
            period_cnt <= set_data_i;
         end else if (period != '0) begin
            if (period_cnt == 1)
               period_cnt <= period;
            else
               period_cnt <= period_cnt - 1'b1;
         end
      end
   end

   // Fires in the last cycle of the count
   assign onetime_int_o  = (onetime_cnt == 1);
   assign periodic_int_o = (period != '0) && (period_cnt == 1);

endmodule

// ==== rtl/u2_ctrl_pkg.sv ====
//////////////////////////////////////////////////
// Shared address map, setting addresses and widths
// for the control-plane subsystem on wb_clk
//////////////////////////////////////////////////

package u2_ctrl_pkg;

   // Bus widths
   localparam int DW       = 32;
   localparam int AW       = 16;
   localparam int DECODE_W = 6;

   // Slave windows, top address bits
   localparam logic [DECODE_W-1:0] SLV_RDBK_ADDR = 6'b110011;
   localparam logic [DECODE_W-1:0] SLV_SET_ADDR  = 6'b110101;
   localparam logic [DECODE_W-1:0] SLV_PIC_ADDR  = 6'b110110;

   typedef logic [7:0] set_addr_t;

   // Setting register addresses
   localparam set_addr_t SR_CLK      = 8'd0;
   localparam set_addr_t SR_SER      = 8'd1;
   localparam set_addr_t SR_ADC      = 8'd2;
   localparam set_addr_t SR_LED      = 8'd3;
   localparam set_addr_t SR_PHY      = 8'd4;
   localparam set_addr_t SR_LED_SRC  = 8'd8;
   // One-shot count at +0, period at +1
   localparam set_addr_t SR_SIMTIMER = 8'd198;

   localparam logic [7:0]    LED_SRC_RESET = 8'h1E;
   localparam logic [DW-1:0] COMPAT_NUM    = 32'd3;

   // Bit positions in the IRQ vector
   localparam int IRQ_ONETIME    = 1;
   localparam int IRQ_PHY        = 4;
   localparam int IRQ_CLK_STATUS = 11;
   localparam int IRQ_PERIODIC   = 12;

   // Three views of one control byte
   typedef struct packed {
      logic [2:0] rsvd;
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
   } clk_view_t;

   typedef struct packed {
      logic [3:0] rsvd;
      logic       enable;
      logic       prbsen;
      logic       loopen;
      logic       rx_en;
   } ser_view_t;

   typedef struct packed {
      logic [3:0] rsvd;
      logic       oe_a;
      logic       on_a;
      logic       oe_b;
      logic       on_b;
   } adc_view_t;

   typedef union packed {
      clk_view_t clk;
      ser_view_t ser;
      adc_view_t adc;
   } ctrl_byte_u;

endpackage

// ==== rtl/u2_ctrl_top.sv ====
//////////////////////////////////////////////////
// Control-plane top level: Wishbone decoder, slaves,
// settings registers and the IRQ vector
//////////////////////////////////////////////////

`timescale 1ns/1ns

module u2_ctrl_top (
   input  logic                      wb_clk,
   input  logic                      wb_rst,
   input  logic [u2_ctrl_pkg::AW-1:0] wb_adr_i,
   input  logic [u2_ctrl_pkg::DW-1:0] wb_dat_i,
   input  logic                      wb_we_i,
   input  logic                      wb_cyc_i,
   input  logic                      wb_stb_i,
   output logic [u2_ctrl_pkg::DW-1:0] wb_dat_o,
   output logic                      wb_ack_o,
   output logic                      wb_err_o,
   output logic                      int_o,
   input  logic                      clk_status_i,
   input  logic                      phy_int_n_i,
   input  logic                      sim_mode_i,
   input  logic [3:0]                clock_divider_i,
   output logic [7:0]                leds_o,
   output logic                      clock_ready_o,
   output logic [1:0]                clk_en_o,
   output logic [1:0]                clk_sel_o,
   output logic                      ser_enable_o,
   output logic                      ser_prbsen_o,
   output logic                      ser_loopen_o,
   output logic                      ser_rx_en_o,
   output logic                      adc_oe_a_o,
   output logic                      adc_on_a_o,
   output logic                      adc_oe_b_o,
   output logic                      adc_on_b_o,
   output logic                      phy_reset_n_o
);
   import u2_ctrl_pkg::*;

   logic          rdbk_stb, rdbk_ack, set_stb, set_ack, pic_stb, pic_ack;
   logic [DW-1:0] rdbk_dat, pic_dat;
   logic          sb_stb;
   set_addr_t     sb_addr;
   logic [DW-1:0] sb_data;
   logic          onetime_int, periodic_int;
   logic [DW-1:0] irq;

   //////////////////////////////////////////////////
   // IRQ vector, sources not kept read as zero
   for (genvar i = 0; i < DW; i++) begin : g_irq
      assign irq[i] = (i == IRQ_ONETIME)    ? onetime_int  :
                      (i == IRQ_PHY)        ? phy_int_n_i  :
                      (i == IRQ_CLK_STATUS) ? clk_status_i :
                      (i == IRQ_PERIODIC)   ? periodic_int : 1'b0;
   end

   wb_slave_decode u_decode (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .adr_i(wb_adr_i), .cyc_i(wb_cyc_i), .stb_i(wb_stb_i),
      .rdbk_ack_i(rdbk_ack), .rdbk_dat_i(rdbk_dat), .set_ack_i(set_ack),
      .pic_ack_i(pic_ack), .pic_dat_i(pic_dat),
      .rdbk_stb_o(rdbk_stb), .set_stb_o(set_stb), .pic_stb_o(pic_stb),
      .dat_o(wb_dat_o), .ack_o(wb_ack_o), .err_o(wb_err_o));

   settings_bus u_settings_bus (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .adr_i(wb_adr_i), .dat_i(wb_dat_i),
      .stb_i(set_stb), .we_i(wb_we_i), .ack_o(set_ack),
      .set_stb_o(sb_stb), .set_addr_o(sb_addr), .set_data_o(sb_data));

   control_regs u_control_regs (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .set_stb_i(sb_stb), .set_addr_i(sb_addr),
      .set_data_i(sb_data), .clk_status_i(clk_status_i), .leds_o(leds_o),
      .clock_ready_o(clock_ready_o), .clk_en_o(clk_en_o), .clk_sel_o(clk_sel_o),
      .ser_enable_o(ser_enable_o), .ser_prbsen_o(ser_prbsen_o),
      .ser_loopen_o(ser_loopen_o), .ser_rx_en_o(ser_rx_en_o),
      .adc_oe_a_o(adc_oe_a_o), .adc_on_a_o(adc_on_a_o),
      .adc_oe_b_o(adc_oe_b_o), .adc_on_b_o(adc_on_b_o), .phy_reset_n_o(phy_reset_n_o));

   simple_timer u_simple_timer (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .set_stb_i(sb_stb), .set_addr_i(sb_addr),
      .set_data_i(sb_data), .onetime_int_o(onetime_int), .periodic_int_o(periodic_int));

   pic u_pic (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .adr_i(wb_adr_i[4:2]), .dat_i(wb_dat_i),
      .we_i(wb_we_i), .stb_i(pic_stb), .cyc_i(wb_cyc_i), .irq_i(irq),
      .dat_o(pic_dat), .ack_o(pic_ack), .int_o(int_o));

   readback_mux u_readback_mux (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .adr_i(wb_adr_i[5:2]), .stb_i(rdbk_stb),
      .irq_i(irq), .sim_mode_i(sim_mode_i), .clock_divider_i(clock_divider_i),
      .dat_o(rdbk_dat), .ack_o(rdbk_ack));

endmodule

// ==== rtl/wb_slave_decode.sv ====
//////////////////////////////////////////////////
// Single-master Wishbone decoder for three windows,
// unmapped windows are answered with err
//////////////////////////////////////////////////

`timescale 1ns/1ns

module wb_slave_decode (
   input  logic                      wb_clk,
   input  logic                      wb_rst,
   input  logic [u2_ctrl_pkg::AW-1:0] adr_i,
   input  logic                      cyc_i,
   input  logic                      stb_i,
   input  logic                      rdbk_ack_i,
   input  logic [u2_ctrl_pkg::DW-1:0] rdbk_dat_i,
   input  logic                      set_ack_i,
   input  logic                      pic_ack_i,
   input  logic [u2_ctrl_pkg::DW-1:0] pic_dat_i,
   output logic                      rdbk_stb_o,
   output logic                      set_stb_o,
   output logic                      pic_stb_o,
   output logic [u2_ctrl_pkg::DW-1:0] dat_o,
   output logic                      ack_o,
   output logic                      err_o
);
   import u2_ctrl_pkg::*;

   logic [DECODE_W-1:0] win;
   logic                rdbk_hit, set_hit, pic_hit;
   logic                req;

   assign win      = adr_i[AW-1 -: DECODE_W];
   assign rdbk_hit = (win == SLV_RDBK_ADDR);
   assign set_hit  = (win == SLV_SET_ADDR);
   assign pic_hit  = (win == SLV_PIC_ADDR);
   assign req      = cyc_i & stb_i;

   // Strobe goes to the matching slave only
   assign rdbk_stb_o = req & rdbk_hit;
   assign set_stb_o  = req & set_hit;
   assign pic_stb_o  = req & pic_hit;

   assign ack_o = rdbk_ack_i | set_ack_i | pic_ack_i;

   // Settings window is write-only and reads zero
   always_comb begin
      case (win)
         SLV_RDBK_ADDR: dat_o = rdbk_dat_i;
         SLV_PIC_ADDR:  dat_o = pic_dat_i;
         default:       dat_o = '0;
      endcase
   end

   // Error responder, same one-cycle rule as the slaves
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         err_o <= 1'b0;
      end else begin
         err_o <= req & ~(rdbk_hit | set_hit | pic_hit) & ~err_o;
      end
   end

endmodule

// ==== tb.f ====
rtl/u2_ctrl_pkg.sv
rtl/wb_slave_decode.sv
rtl/settings_bus.sv
rtl/control_regs.sv
rtl/simple_timer.sv
rtl/pic.sv
rtl/readback_mux.sv
rtl/u2_ctrl_top.sv
bench/u2_ctrl_assertions.sv
bench/tb_u2_ctrl.sv
